// ==== backend_pkg.sv ====
package backend_pkg;

	////////////////////
	// Video types
	////////////////////

	typedef logic [7:0] color8_t;	// One colour channel at full width

	// Pixel as it leaves the core
	typedef struct packed {
		color8_t r;	// Red channel
		color8_t g;	// Green channel
		color8_t b;	// Blue channel
	} rgb_pixel_t;

	// Raw syncs from the core
	typedef struct packed {
		logic hs;	// Horizontal sync, active low
		logic vs;	// Vertical sync, active low
		logic cs;	// Composite sync, active low
	} sync_t;

	////////////////////
	// Audio and keys
	////////////////////

	typedef logic [15:0] sample_t;	// Sample in memory byte order
	typedef logic [7:0]  keycode_t;	// Raw key code

	////////////////////
	// Default sizes
	////////////////////

	// Board VGA DAC width per channel
	localparam int DEF_VGA_WIDTH = 6;

	// Clocks per CD audio tick
	localparam int DEF_AUD_TICK_DIV = 643;

	// Samples held in the CD audio FIFO
	localparam int DEF_AUD_FIFO_DEPTH = 16;

	// Clocks per keyboard slot
	// Stands in for the old 7 MHz enable
	localparam int DEF_KBD_SLOT_DIV = 4;

endpackage

// ==== osd_overlay.sv ====
`timescale 1ns/10ps

module osd_overlay (
	input  logic                    CLK_114,
	input  logic                    rst,
	input  backend_pkg::rgb_pixel_t pix_in,	// Pixel from the core
	input  backend_pkg::sync_t      sync_in,	// Syncs from the core
	input  logic                    osd_window,	// Inside OSD area
	input  logic                    osd_pixel,	// OSD foreground dot
	output backend_pkg::rgb_pixel_t pix_mix,	// Overlaid pixel, registered
	output backend_pkg::sync_t      sync_mix	// Syncs, same stage
);

	////////////////////
	// OSD colour
	////////////////////

	logic [1:0] osd_r;	// Top two bits inside window
	logic [1:0] osd_g;
	logic [1:0] osd_b;
	backend_pkg::rgb_pixel_t pix_ovl;	// Overlay result before the register

	assign osd_r = osd_pixel ? 2'b11 : 2'b00;	// White dot or dark
	assign osd_g = osd_pixel ? 2'b11 : 2'b00;
	assign osd_b = osd_pixel ? 2'b11 : 2'b10;	// Blue tint behind text

	// Picture shifted down two bits under the OSD
	always_comb begin
		pix_ovl = pix_in;	// Pass through outside window
		if (osd_window) begin
			pix_ovl.r = {osd_r, pix_in.r[7:2]};
			pix_ovl.g = {osd_g, pix_in.g[7:2]};
			pix_ovl.b = {osd_b, pix_in.b[7:2]};
		end
	end

	////////////////////
	// Stage register
	////////////////////

	always_ff @(posedge CLK_114) begin
		if (rst) begin
			pix_mix  <= '0;
			sync_mix <= '0;
		end else begin
			pix_mix  <= pix_ovl;	// New pixel every clock
			sync_mix <= sync_in;	// Keeps syncs in step with pixel
		end
	end

	// Core must hand over clean pixels once out of reset
	a_pix_known : assert property (
		@(posedge CLK_114) disable iff (rst)
		1'b1 |=> !$isunknown(pix_mix)
	) else $error("osd_overlay: unknown bits on pix_mix");

endmodule

// ==== vga_output.sv ====
`timescale 1ns/10ps

module vga_output #(
	parameter int VGA_WIDTH = backend_pkg::DEF_VGA_WIDTH	// Board DAC bits
) (
	input  logic                    CLK_114,
	input  logic                    rst,
	input  backend_pkg::rgb_pixel_t pix_mix,	// From overlay stage
	input  backend_pkg::sync_t      sync_mix,	// From overlay stage
	input  logic                    selcsync,	// Composite sync mode
	input  logic                    hsyncpol,	// Invert hsync
	input  logic                    vsyncpol,	// Invert vsync
	output logic                    vga_hs,
	output logic                    vga_vs,
	output logic [VGA_WIDTH-1:0]    vga_r,
	output logic [VGA_WIDTH-1:0]    vga_g,
	output logic [VGA_WIDTH-1:0]    vga_b
);

	////////////////////
	// Sync polarity
	////////////////////

	logic hs_flip;	// Invert hsync this frame
	logic vs_flip;	// Invert vsync this frame

	// Composite mode keeps the core polarity
	assign hs_flip = hsyncpol & ~selcsync;
	assign vs_flip = vsyncpol & ~selcsync;

	////////////////////
	// Output registers
	////////////////////

	always_ff @(posedge CLK_114) begin
		if (rst) begin
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
		end else begin
			vga_hs <= sync_mix.hs ^ hs_flip;
			vga_vs <= sync_mix.vs ^ vs_flip;
			// Plain truncation to DAC width
			vga_r  <= pix_mix.r[7 -: VGA_WIDTH];	// Keep the MSBs
			vga_g  <= pix_mix.g[7 -: VGA_WIDTH];
			vga_b  <= pix_mix.b[7 -: VGA_WIDTH];
		end
	end

endmodule

// ==== audio_sample_fifo.sv ====
`timescale 1ns/10ps

module audio_sample_fifo #(
	parameter int AUD_FIFO_DEPTH = backend_pkg::DEF_AUD_FIFO_DEPTH	// Samples held
) (
	input  logic                 CLK_114,
	input  logic                 rst,
	input  logic                 flush,	// Drop everything held
	input  logic                 samp_wr,	// Write strobe
	input  backend_pkg::sample_t samp_data,
	input  logic                 pop,	// Pop strobe from pacer
	output backend_pkg::sample_t head_data,	// Oldest sample, fall through
	output logic                 not_empty
);

	localparam int PTR_W = (AUD_FIFO_DEPTH > 1) ? $clog2(AUD_FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(AUD_FIFO_DEPTH + 1);

	backend_pkg::sample_t mem [AUD_FIFO_DEPTH];	// Sample store
	logic [PTR_W-1:0] wr_ptr;	// Next free slot
	logic [PTR_W-1:0] rd_ptr;	// Head slot
	logic [CNT_W-1:0] count;	// Samples held
	logic             wr_ok;	// Write accepted
	logic             rd_ok;	// Pop accepted

	// Wrap at depth so any size works
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(AUD_FIFO_DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign wr_ok     = samp_wr && (count != CNT_W'(AUD_FIFO_DEPTH));	// Drop when full
	assign rd_ok     = pop && (count != '0);	// Ignore when empty
	assign head_data = mem[rd_ptr];
	assign not_empty = (count != '0);

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge CLK_114) begin
		if (wr_ok) begin
			mem[wr_ptr] <= samp_data;
		end
	end

	////////////////////
	// Pointers and count
	////////////////////

	always_ff @(posedge CLK_114) begin
		if (rst || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;	// Flush empties at once
		end else begin
			if (wr_ok) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (rd_ok) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

	a_count_range : assert property (
		@(posedge CLK_114) disable iff (rst)
		count <= CNT_W'(AUD_FIFO_DEPTH)
	) else $error("audio_sample_fifo: count above depth");

endmodule

// ==== audio_pacer.sv ====
`timescale 1ns/10ps

module audio_pacer #(
	parameter int AUD_TICK_DIV = backend_pkg::DEF_AUD_TICK_DIV	// Clocks per tick
) (
	input  logic                 CLK_114,
	input  logic                 rst,
	input  logic                 aud_ena,	// CD audio running
	input  backend_pkg::sample_t head_data,	// FIFO head
	input  logic                 not_empty,
	output logic                 pop,	// Take head from FIFO
	output backend_pkg::sample_t aud_left,	// Swapped left sample
	output backend_pkg::sample_t aud_right	// Swapped right sample
);

	localparam int CNT_W = (AUD_TICK_DIV > 1) ? $clog2(AUD_TICK_DIV) : 1;

	typedef enum logic {
		PH_WAIT,	// Waiting for next tick
		PH_RIGHT	// Right pop due this clock
	} pop_phase_e;

	logic [CNT_W-1:0] tick_cnt;	// Tick divider
	logic             tick;	// Divider wrap, left pop
	pop_phase_e       phase;
	logic             right_pop;	// Follow-up pop for right

	// Memory holds big endian samples
	function automatic backend_pkg::sample_t byte_swap(input backend_pkg::sample_t s);
		return {s[7:0], s[15:8]};
	endfunction

	assign tick      = aud_ena && (tick_cnt == CNT_W'(AUD_TICK_DIV - 1));
	assign right_pop = aud_ena && (phase == PH_RIGHT);
	assign pop       = tick || right_pop;

	////////////////////
	// Divider and phase
	////////////////////

	always_ff @(posedge CLK_114) begin
		if (rst || !aud_ena) begin
			tick_cnt <= '0;	// Held while stopped
			phase    <= PH_WAIT;
		end else begin
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			phase    <= tick ? PH_RIGHT : PH_WAIT;	// Right one clock after left
		end
	end

	////////////////////
	// Holding registers
	////////////////////

	always_ff @(posedge CLK_114) begin
		if (rst) begin
			aud_left  <= '0;
			aud_right <= '0;
		end else begin
			if (tick && not_empty) begin
				aud_left <= byte_swap(head_data);	// Underrun keeps last value
			end
			if (right_pop && not_empty) begin
				aud_right <= byte_swap(head_data);
			end
		end
	end

	// Only the left/right pair pops back to back
	a_pop_pair : assert property (
		@(posedge CLK_114) disable iff (rst)
		pop ##1 pop |=> !pop
	) else $error("audio_pacer: pop held beyond the right follow-up");

endmodule

// ==== key_event_merge.sv ====
`timescale 1ns/10ps

module key_event_merge #(
	parameter int KBD_SLOT_DIV = backend_pkg::DEF_KBD_SLOT_DIV	// Clocks per slot
) (
	input  logic                  CLK_114,
	input  logic                  rst,
	input  logic                  host_key_stb,	// Host translated key
	input  backend_pkg::keycode_t host_key,
	input  logic                  dock_key_stb,	// Docking station key
	input  backend_pkg::keycode_t dock_key,
	output logic                  key_stb,	// One clock per event
	output backend_pkg::keycode_t key_data
);

	localparam int SLOT_W = (KBD_SLOT_DIV > 1) ? $clog2(KBD_SLOT_DIV) : 1;

	logic [SLOT_W-1:0]     slot_cnt;	// Slot divider
	logic                  slot_wrap;	// Last clock of slot
	logic                  pending;	// Key waiting for a slot
	backend_pkg::keycode_t key_code;	// Waiting key

	assign slot_wrap = (slot_cnt == SLOT_W'(KBD_SLOT_DIV - 1));
	assign key_stb   = slot_wrap && pending;	// Fire on the slot edge
	assign key_data  = key_code;

	////////////////////
	// Slot counter
	////////////////////

	always_ff @(posedge CLK_114) begin
		if (rst) begin
			slot_cnt <= '0;
		end else begin
			slot_cnt <= slot_wrap ? '0 : slot_cnt + 1'b1;
		end
	end

	////////////////////
	// Merge and hold
	////////////////////

	always_ff @(posedge CLK_114) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (host_key_stb || dock_key_stb) begin
			pending <= 1'b1;	// Newer key replaces one still waiting
		end else if (key_stb) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge CLK_114) begin
		if (host_key_stb) begin
			key_code <= host_key;	// Host wins a tie
		end else if (dock_key_stb) begin
			key_code <= dock_key;
		end
	end

	// Strobes land on slot wraps so they sit a full slot apart
	a_slot_spacing : assert property (
		@(posedge CLK_114) disable iff (rst)
		key_stb |=> !key_stb [*(KBD_SLOT_DIV - 1)]
	) else $error("key_event_merge: key_stb off the slot boundary");

endmodule

// ==== output_backend_top.sv ====
`timescale 1ns/10ps

module output_backend_top #(
	parameter int VGA_WIDTH      = backend_pkg::DEF_VGA_WIDTH,
	parameter int AUD_TICK_DIV   = backend_pkg::DEF_AUD_TICK_DIV,
	parameter int AUD_FIFO_DEPTH = backend_pkg::DEF_AUD_FIFO_DEPTH,
	parameter int KBD_SLOT_DIV   = backend_pkg::DEF_KBD_SLOT_DIV
) (
	input  logic                    CLK_114,
	input  logic                    rst,
	// Video
	input  backend_pkg::rgb_pixel_t pix_in,
	input  backend_pkg::sync_t      sync_in,
	input  logic                    osd_window,
	input  logic                    osd_pixel,
	input  logic                    selcsync,
	input  logic                    hsyncpol,
	input  logic                    vsyncpol,
	output logic                    vga_hs,
	output logic                    vga_vs,
	output logic [VGA_WIDTH-1:0]    vga_r,
	output logic [VGA_WIDTH-1:0]    vga_g,
	output logic [VGA_WIDTH-1:0]    vga_b,
	// CD audio
	input  logic                    samp_wr,
	input  backend_pkg::sample_t    samp_data,
	input  logic                    aud_ena,
	output backend_pkg::sample_t    aud_left,
	output backend_pkg::sample_t    aud_right,
	// Keyboard
	input  logic                    host_key_stb,
	input  backend_pkg::keycode_t   host_key,
	input  logic                    dock_key_stb,
	input  backend_pkg::keycode_t   dock_key,
	output logic                    key_stb,
	output backend_pkg::keycode_t   key_data
);

	backend_pkg::rgb_pixel_t pix_mix;	// Between video stages
	backend_pkg::sync_t      sync_mix;
	backend_pkg::sample_t    head_data;	// FIFO head to pacer
	logic                    not_empty;
	logic                    pop;
	logic                    flush;	// Stopped audio drops old samples

	assign flush = ~aud_ena;

	////////////////////
	// Video path
	////////////////////

	osd_overlay u_osd (
		.CLK_114 (CLK_114), .rst (rst), .pix_in (pix_in), .sync_in (sync_in),
		.osd_window (osd_window), .osd_pixel (osd_pixel),
		.pix_mix (pix_mix), .sync_mix (sync_mix)
	);

	vga_output #(.VGA_WIDTH(VGA_WIDTH)) u_vga (
		.CLK_114 (CLK_114), .rst (rst), .pix_mix (pix_mix), .sync_mix (sync_mix),
		.selcsync (selcsync), .hsyncpol (hsyncpol), .vsyncpol (vsyncpol),
		.vga_hs (vga_hs), .vga_vs (vga_vs),
		.vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b)
	);

	////////////////////
	// Audio path
	////////////////////

	audio_sample_fifo #(.AUD_FIFO_DEPTH(AUD_FIFO_DEPTH)) u_fifo (
		.CLK_114 (CLK_114), .rst (rst), .flush (flush),
		.samp_wr (samp_wr), .samp_data (samp_data), .pop (pop),
		.head_data (head_data), .not_empty (not_empty)
	);

	audio_pacer #(.AUD_TICK_DIV(AUD_TICK_DIV)) u_pacer (
		.CLK_114 (CLK_114), .rst (rst), .aud_ena (aud_ena),
		.head_data (head_data), .not_empty (not_empty), .pop (pop),
		.aud_left (aud_left), .aud_right (aud_right)
	);

	////////////////////
	// Keyboard path
	////////////////////

	key_event_merge #(.KBD_SLOT_DIV(KBD_SLOT_DIV)) u_keys (
		.CLK_114 (CLK_114), .rst (rst),
		.host_key_stb (host_key_stb), .host_key (host_key),
		.dock_key_stb (dock_key_stb), .dock_key (dock_key),
		.key_stb (key_stb), .key_data (key_data)
	);

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
	parameter real PERIOD_NS = 20.0	// Full clock period
) (
	output logic CLK_114
);

	initial begin
		CLK_114 = 1'b0;
		forever begin
			#(PERIOD_NS / 2.0) CLK_114 = ~CLK_114;	// Half period per phase
		end
	end

endmodule

// ==== tb_output_backend.sv ====
`timescale 1ns/10ps

module tb_output_backend;

	localparam int VGA_W       = backend_pkg::DEF_VGA_WIDTH;
	localparam int TICK_DIV    = backend_pkg::DEF_AUD_TICK_DIV;
	localparam int FIFO_DEPTH  = backend_pkg::DEF_AUD_FIFO_DEPTH;
	localparam int SLOT_DIV    = backend_pkg::DEF_KBD_SLOT_DIV;
	localparam int NUM_TESTS   = 5;
	localparam int CYCLE_LIMIT = NUM_TESTS * 3 * TICK_DIV + 2000;	// Three ticks per test
	localparam time DRIVE_DLY  = 2ns;

	logic CLK_114;
	logic rst;
	backend_pkg::rgb_pixel_t pix_in;
	backend_pkg::sync_t      sync_in;
	logic osd_window, osd_pixel, selcsync, hsyncpol, vsyncpol;
	logic vga_hs, vga_vs;
	logic [VGA_W-1:0] vga_r, vga_g, vga_b;
	logic samp_wr, aud_ena, host_key_stb, dock_key_stb, key_stb;
	backend_pkg::sample_t  samp_data, aud_left, aud_right;
	backend_pkg::keycode_t host_key, dock_key, key_data;

	int                    errors;	// Failed checks so far
	int                    cycles;	// Timeout counter
	int                    post_rst;	// Clocks since reset, saturates at 3
	int                    stb_count;	// key_stb pulses seen per event
	logic [31:0]           lfsr;
	logic                  audio_chk;	// One-clock audio compare point
	logic                  kbd_chk;	// One-clock strobe count compare
	backend_pkg::sample_t  exp_left, exp_right;
	backend_pkg::keycode_t exp_key;

	tb_clock u_clk (.CLK_114(CLK_114));

	output_backend_top #(
		.VGA_WIDTH(VGA_W), .AUD_TICK_DIV(TICK_DIV),
		.AUD_FIFO_DEPTH(FIFO_DEPTH), .KBD_SLOT_DIV(SLOT_DIV)
	) DUT (
		.CLK_114(CLK_114), .rst(rst), .pix_in(pix_in), .sync_in(sync_in),
		.osd_window(osd_window), .osd_pixel(osd_pixel), .selcsync(selcsync),
		.hsyncpol(hsyncpol), .vsyncpol(vsyncpol), .vga_hs(vga_hs), .vga_vs(vga_vs),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .samp_wr(samp_wr),
		.samp_data(samp_data), .aud_ena(aud_ena), .aud_left(aud_left),
		.aud_right(aud_right), .host_key_stb(host_key_stb), .host_key(host_key),
		.dock_key_stb(dock_key_stb), .dock_key(dock_key), .key_stb(key_stb),
		.key_data(key_data)
	);

	////////////////////
	// Helpers
	////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val  = {val[30:0], fb};	// One step per bit
		end
		return val;
	endfunction

	// Overlay then keep the top VGA_W bits
	function automatic logic [VGA_W-1:0] exp_color(input backend_pkg::color8_t c,
			input logic win, input logic dot, input logic is_blue);
		logic [1:0]          osd;
		backend_pkg::color8_t m;
		osd = dot ? 2'b11 : (is_blue ? 2'b10 : 2'b00);	// Text or background
		m   = win ? {osd, c[7:2]} : c;
		return VGA_W'(m >> (8 - VGA_W));
	endfunction

	function automatic backend_pkg::sample_t swap_bytes(input backend_pkg::sample_t s);
		return {s[7:0], s[15:8]};
	endfunction

	task automatic flag_error(input string msg);
		errors++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	task automatic next_cycle();
		@(posedge CLK_114);
		#DRIVE_DLY;	// Inputs change clear of the edge
	endtask

	task automatic write_sample(input backend_pkg::sample_t s);
		samp_wr   = 1'b1;
		samp_data = s;
		next_cycle();
		samp_wr   = 1'b0;
	endtask

	task automatic check_audio(input backend_pkg::sample_t l, input backend_pkg::sample_t r);
		exp_left  = l;
		exp_right = r;
		audio_chk = 1'b1;
		next_cycle();
		audio_chk = 1'b0;
	endtask

	// One event, then count strobes over a full slot and a margin
	task automatic key_event(input logic h_stb, input backend_pkg::keycode_t h,
			input logic d_stb, input backend_pkg::keycode_t d, input backend_pkg::keycode_t exp);
		exp_key      = exp;
		host_key_stb = h_stb;
		host_key     = h;
		dock_key_stb = d_stb;
		dock_key     = d;
		next_cycle();
		host_key_stb = 1'b0;
		dock_key_stb = 1'b0;
		stb_count    = 0;
		repeat (SLOT_DIV + 1) begin
			@(negedge CLK_114);
			if (key_stb) stb_count++;	// Mid-cycle, outputs settled
		end
		next_cycle();
		kbd_chk = 1'b1;
		next_cycle();
		kbd_chk = 1'b0;
	endtask

	////////////////////
	// Checks
	////////////////////

	always @(posedge CLK_114) begin
		if (rst) post_rst <= 0;
		else if (post_rst < 3) post_rst <= post_rst + 1;
	end

	a_vga_r : assert property (@(posedge CLK_114) disable iff (post_rst < 3)
		vga_r == exp_color($past(pix_in.r, 2), $past(osd_window, 2), $past(osd_pixel, 2), 1'b0))
		else flag_error("vga_r differs from overlay and truncation");
	a_vga_g : assert property (@(posedge CLK_114) disable iff (post_rst < 3)
		vga_g == exp_color($past(pix_in.g, 2), $past(osd_window, 2), $past(osd_pixel, 2), 1'b0))
		else flag_error("vga_g differs from overlay and truncation");
	a_vga_b : assert property (@(posedge CLK_114) disable iff (post_rst < 3)
		vga_b == exp_color($past(pix_in.b, 2), $past(osd_window, 2), $past(osd_pixel, 2), 1'b1))
		else flag_error("vga_b differs from overlay and truncation");
	// Polarity controls act on the output stage
	a_vga_hs : assert property (@(posedge CLK_114) disable iff (post_rst < 3)
		vga_hs == ($past(sync_in.hs, 2) ^ ($past(hsyncpol) & ~$past(selcsync))))
		else flag_error("vga_hs polarity wrong");
	a_vga_vs : assert property (@(posedge CLK_114) disable iff (post_rst < 3)
		vga_vs == ($past(sync_in.vs, 2) ^ ($past(vsyncpol) & ~$past(selcsync))))
		else flag_error("vga_vs polarity wrong");
	a_aud_left : assert property (@(posedge CLK_114) audio_chk |-> aud_left == exp_left)
		else flag_error($sformatf("aud_left %h, expected %h", aud_left, exp_left));
	a_aud_right : assert property (@(posedge CLK_114) audio_chk |-> aud_right == exp_right)
		else flag_error($sformatf("aud_right %h, expected %h", aud_right, exp_right));
	a_key_data : assert property (@(posedge CLK_114) key_stb |-> key_data == exp_key)
		else flag_error($sformatf("key_data %h, expected %h", key_data, exp_key));
	a_key_once : assert property (@(posedge CLK_114) kbd_chk |-> stb_count == 1)
		else flag_error($sformatf("%0d key_stb pulses for one event", stb_count));

	always @(posedge CLK_114) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run still busy after %0d clock cycles", CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	// Random video every clock while the sync controls step through all eight settings
	initial begin : video_drive
		logic [31:0] r;
		logic [2:0]  combo;
		int          step;
		lfsr = 32'he553;
		combo = 3'd0;
		step = 0;
		pix_in = '0;
		sync_in = '0;
		{osd_window, osd_pixel, selcsync, hsyncpol, vsyncpol} = '0;
		forever begin
			next_cycle();
			r          = rand_bits(24);
			pix_in     = backend_pkg::rgb_pixel_t'(r[23:0]);
			r          = rand_bits(5);
			sync_in    = backend_pkg::sync_t'(r[2:0]);
			osd_window = r[3];
			osd_pixel  = r[4];
			if (step % 8 == 0) begin
				{selcsync, hsyncpol, vsyncpol} = combo;
				combo = combo + 3'd1;
			end
			step++;
		end
	end

	initial begin : main_seq
		backend_pkg::sample_t samples [8];
		samples = '{16'h1234, 16'hA55A, 16'hBEEF, 16'h0F1E, 16'hC0DE, 16'h7788, 16'h9AB1, 16'h4C3D};
		errors = 0;
		cycles = 0;
		stb_count = 0;
		{rst, samp_wr, aud_ena, host_key_stb, dock_key_stb} = 5'b10000;
		{audio_chk, kbd_chk} = 2'b00;
		samp_data = '0;
		host_key = '0;
		dock_key = '0;
		{exp_left, exp_right, exp_key} = '0;
		repeat (16) @(posedge CLK_114);
		#DRIVE_DLY;
		rst = 1'b0;
		repeat (4) next_cycle();

		// Tie, dock only and host only keys at varying slot phase
		for (int i = 0; i < 9; i++) begin
			case (i % 3)
				0: key_event(1'b1, 8'(8'h10 + i), 1'b1, 8'(8'h80 + i), 8'(8'h10 + i));
				1: key_event(1'b0, 8'(8'h10 + i), 1'b1, 8'(8'h80 + i), 8'(8'h80 + i));
				default: key_event(1'b1, 8'(8'h10 + i), 1'b0, 8'(8'h80 + i), 8'(8'h10 + i));
			endcase
			repeat (i % 4) next_cycle();
		end

		// Four audio samples give two left/right pairs
		aud_ena = 1'b1;	// Divider starts from zero here
		for (int i = 0; i < 4; i++) write_sample(samples[i]);
		repeat (TICK_DIV) next_cycle();
		check_audio(swap_bytes(samples[0]), swap_bytes(samples[1]));
		repeat (TICK_DIV) next_cycle();
		check_audio(swap_bytes(samples[2]), swap_bytes(samples[3]));
		repeat (TICK_DIV) next_cycle();	// Tick on an empty FIFO
		check_audio(swap_bytes(samples[2]), swap_bytes(samples[3]));

		// Stale samples dropped by the stop
		write_sample(samples[4]);
		write_sample(samples[5]);
		aud_ena = 1'b0;
		repeat (4) next_cycle();
		aud_ena = 1'b1;
		write_sample(samples[6]);
		write_sample(samples[7]);
		repeat (TICK_DIV) next_cycle();
		check_audio(swap_bytes(samples[6]), swap_bytes(samples[7]));

		repeat (4) next_cycle();
		$display("Run complete after %0d cycles, %0d errors", cycles, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== list.f ====
backend_pkg.sv
osd_overlay.sv
vga_output.sv
audio_sample_fifo.sv
audio_pacer.sv
key_event_merge.sv
output_backend_top.sv
tb_clock.sv
tb_output_backend.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the output back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f \
	--top-module tb_output_backend -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
	echo "Result: pass"
	exit 0
else
	echo "Result: fail"
	exit 1
fi
